//--- run.sh
#!/bin/sh
# Build the thresholding testbench with Verilator and run it
# Exit status is nonzero when the build fails or the run ends in $fatal
verilator --binary --timing -Wno-fatal --top-module thresholdingTb -f src.f -o thresholdingSim \
	&& ./obj_dir/thresholdingSim \
	|| { echo "Thresholding simulation did not pass"; exit 1; }

//--- src.f
verilog/thrBusPkg.sv
verilog/thrStreamPkg.sv
verilog/configPort.sv
verilog/thresholdStage.sv
verilog/thresholdCore.sv
verilog/outputSkidBuffer.sv
verilog/thresholdingTop.sv
testbench/thresholdingTb.sv

//--- testbench/thresholdingTb.sv
// Testbench for the thresholding unit
// Loads tables over the config bus and checks streamed results against a reference model
`timescale 1ns/1ps
`default_nettype none

module thresholdingTb;
	localparam int N = 4;
	localparam int M = 8;
	localparam int C = 3;
	localparam int BIAS = -2;
	localparam int Thr = 2 ** N - 1;  // Thresholds per channel
	localparam int CycleLimit = 4000; // 60 writes of ~8 cycles plus ~250 beats at half rate, slack

	logic clk;
	logic rst;
	thrBusPkg::axiWriteReq writeReq;
	thrBusPkg::axiWriteRsp writeRsp;
	thrBusPkg::axiReadReq readReq;
	thrBusPkg::axiReadRsp readRsp;
	thrStreamPkg::inBeat inData;
	logic inReady;
	thrStreamPkg::outBeat outData;
	logic outReady = 1'b1;

	integer seed = 8;
	int cycleCount = 0;
	logic [M-1:0] thrTable [C][Thr];  // Reference copy of the tables
	logic [M-1:0] pending [$];        // Values still to send
	logic [7:0] expected [$];         // Model results in input order
	int nextChan = 0;                 // Channel of the next accepted beat
	int outCount = 0;
	int stalledCycles = 0;
	bit stallOn = 1'b0;
	bit sawTransfer = 1'b0;           // Output handshake in the last cycle
	thrStreamPkg::outBeat lastBeat;
	thrStreamPkg::outBeat expBeat;

	thresholdingTop #(.N(N), .M(M), .C(C), .BIAS(BIAS)) UUT (
		.clk(clk),
		.rst(rst),
		.writeReq(writeReq),
		.writeRsp(writeRsp),
		.readReq(readReq),
		.readRsp(readRsp),
		.inData(inData),
		.inReady(inReady),
		.outData(outData),
		.outReady(outReady)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "Run stopped");
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= CycleLimit) begin
			stopRun($sformatf("Run hit the cycle limit of %0d cycles", CycleLimit));
		end
	end

	task automatic checkResult(input thrStreamPkg::outBeat got, input thrStreamPkg::outBeat exp,
			input int beatNum);
		if (got !== exp) begin
			stopRun($sformatf("[ERROR] %0d ns: output beat %0d is %0d, expected %0d",
				$time, beatNum, got.data, exp.data));
		end
	endtask

	task automatic checkReadRsp(input thrBusPkg::axiReadRsp got, input thrBusPkg::axiReadRsp exp);
		if (got !== exp) begin
			stopRun($sformatf("[ERROR] %0d ns: read rsp v=%0b data=%h resp=%0d, expected v=%0b",
				$time, got.rValid, got.rData, got.rResp, exp.rValid));
		end
	endtask

	// Count of thresholds at or below the value, plus the offset
	function automatic logic [7:0] modelOut(input int ch, input logic [M-1:0] v);
		int count;
		count = 0;
		for (int i = 0; i < Thr; i++) begin
			if (thrTable[ch][i] <= v) count++;
		end
		return 8'(count + BIAS);
	endfunction

	// Output side, checks the beat taken on the edge just passed
	always @(negedge clk) begin
		if (sawTransfer) begin
			if (expected.size() == 0) begin
				stopRun("An output beat arrived with no input left to match it");
			end
			expBeat = '{valid: 1'b1, data: expected.pop_front()};
			checkResult(lastBeat, expBeat, outCount);
			outCount++;
		end
		outReady = stallOn ? (($random(seed) % 2) != 0) : 1'b1;  // About half stalled
		sawTransfer = !rst && outData.valid && outReady;
		lastBeat = outData;
	end

	task automatic offerAddr(input logic [15:0] addr);
		writeReq.awValid = 1'b1;
		writeReq.awAddr = addr;
		while (!writeRsp.awReady) @(negedge clk);
		@(negedge clk);  // Taken on the edge just passed
		writeReq.awValid = 1'b0;
	endtask

	task automatic offerData(input logic [31:0] data);
		writeReq.wValid = 1'b1;
		writeReq.wData = data;
		while (!writeRsp.wReady) @(negedge clk);
		@(negedge clk);
		writeReq.wValid = 1'b0;
	endtask

	task automatic writeThreshold(input int ch, input int idx, input logic [M-1:0] value,
			input bit addrFirst);
		logic [15:0] addr;
		logic [31:0] data;
		addr = 16'((ch << (N + 2)) | (idx << 2) | (idx % 4));  // Junk in bits 1:0
		data = 32'hDEADBE00 | 32'(value);                       // Junk above M
		@(negedge clk);
		if (addrFirst) offerAddr(addr);
		else offerData(data);
		if (writeRsp.bValid) stopRun("Write response rose with only one half of the write held");
		if (addrFirst) offerData(data);
		else offerAddr(addr);
		while (!writeRsp.bValid) @(negedge clk);
		if (writeRsp.bResp !== thrBusPkg::respOkay) begin
			stopRun($sformatf("[ERROR] %0d ns: write response %0d, expected OKAY",
				$time, writeRsp.bResp));
		end
		writeReq.bReady = 1'b1;
		@(negedge clk);
		writeReq.bReady = 1'b0;
		if (writeRsp.bValid) stopRun("Write response stayed up after its handshake");
	endtask

	// Ascending random table, then written with mixed half order
	task automatic loadChannel(input int ch, input int base, input int stepMask);
		int t;
		t = base + ($random(seed) & 7);
		for (int i = 0; i < Thr; i++) begin
			thrTable[ch][i] = M'(t);
			t = t + 1 + ($random(seed) & stepMask);
		end
		for (int i = 0; i < Thr; i++) begin
			writeThreshold(ch, i, thrTable[ch][i], ((i + ch) % 2) == 0);
		end
	endtask

	task automatic readOnce(input logic [15:0] addr);
		thrBusPkg::axiReadRsp expRsp;
		expRsp = '{arReady: 1'b0, rValid: 1'b1, rData: '1, rResp: thrBusPkg::respOkay};
		@(negedge clk);
		readReq.arValid = 1'b1;
		readReq.arAddr = addr;
		while (!readRsp.arReady) @(negedge clk);
		@(negedge clk);
		readReq.arValid = 1'b0;
		while (!readRsp.rValid) @(negedge clk);
		checkReadRsp(readRsp, expRsp);
		@(negedge clk);
		checkReadRsp(readRsp, expRsp);  // Held while rReady is low
		readReq.rReady = 1'b1;
		@(negedge clk);
		readReq.rReady = 1'b0;
		expRsp.arReady = 1'b1;
		expRsp.rValid = 1'b0;
		checkReadRsp(readRsp, expRsp);
	endtask

	// Sends the pending values, one per accepted cycle
	task automatic streamValues();
		while (pending.size() > 0) begin
			@(negedge clk);
			inData.valid = 1'b1;
			inData.data = 16'(pending[0]);
			if (inReady) begin
				expected.push_back(modelOut(nextChan, pending[0]));
				nextChan = (nextChan + 1) % C;
				void'(pending.pop_front());
			end else begin
				stalledCycles++;
			end
		end
		@(negedge clk);
		inData.valid = 1'b0;
	endtask

	task automatic waitDrain();
		while (expected.size() > 0) @(negedge clk);
		repeat (N + 4) @(negedge clk);  // Room for a stray extra beat
	endtask

	task automatic streamRandom(input int count);
		for (int i = 0; i < count; i++) begin
			pending.push_back(M'($random(seed)));
		end
		streamValues();
		waitDrain();
	endtask

	task automatic streamBoundaries();
		int pos;
		int ch;
		pos = 0;
		for (int k = 0; k < Thr; k++) begin
			for (int d = 0; d < 2; d++) begin
				for (int j = 0; j < C; j++) begin
					ch = (nextChan + pos) % C;
					pending.push_back(thrTable[ch][k] - M'(d));  // On and just below
					pos++;
				end
			end
		end
		for (int j = 0; j < 2 * C; j++) begin
			pending.push_back((j < C) ? {M{1'b0}} : {M{1'b1}});
		end
		streamValues();
		waitDrain();
	endtask

	task automatic streamStalled(input int count);
		for (int i = 0; i < count; i++) begin
			pending.push_back(M'($random(seed)));
		end
		stalledCycles = 0;
		@(posedge clk);
		stallOn = 1'b1;
		streamValues();
		waitDrain();
		@(posedge clk);
		stallOn = 1'b0;
		if (stalledCycles == 0) stopRun("Output stalls never held back the input");
	endtask

	initial begin
		rst = 1'b1;
		writeReq = '0;
		readReq = '0;
		inData = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int ch = 0; ch < C; ch++) begin
			loadChannel(ch, 0, 15);
		end
		for (int k = 0; k < 4; k++) begin
			readOnce(16'(k * 68 + 1));
		end
		streamRandom(60);
		streamBoundaries();
		streamStalled(60);
		loadChannel(1, 120, 7);  // New table for channel 1 only
		streamRandom(30);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/configPort.sv
// Threshold configuration slave
// Latches AXI-Lite address and data halves and issues table writes on the response
`timescale 1ns/1ps
`default_nettype none

module configPort #(
	parameter int unsigned N = 4,  // Output precision
	parameter int unsigned M = 8,  // Threshold precision
	parameter int unsigned C = 3   // Channels
) (
	input logic clk,
	input logic rst,
	input thrBusPkg::axiWriteReq writeReq,
	output thrBusPkg::axiWriteRsp writeRsp,
	input thrBusPkg::axiReadReq readReq,
	output thrBusPkg::axiReadRsp readRsp,
	output thrBusPkg::thresholdWrite thrWrite
);
	localparam int unsigned ChanBits = (C < 2) ? 1 : $clog2(C);

	logic addrBusy;  // Address half held
	logic dataBusy;  // Data half held
	logic [ChanBits-1:0] wrChannel;
	logic [N-1:0] wrIndex;
	logic [M-1:0] wrValue;
	logic respDone;  // B handshake
	logic rdBusy;    // Read response pending

	assign respDone = addrBusy && dataBusy && writeReq.bReady;

	// Halves are taken independently, freed together
	always_ff @(posedge clk) begin
		if (rst || respDone) begin
			addrBusy <= 1'b0;
			dataBusy <= 1'b0;
		end else begin
			if (!addrBusy && writeReq.awValid) begin
				addrBusy <= 1'b1;
			end
			if (!dataBusy && writeReq.wValid) begin
				dataBusy <= 1'b1;
			end
		end
	end

	// Byte address to word address, bits 1:0 dropped
	always_ff @(posedge clk) begin
		if (!addrBusy) begin
			wrIndex <= writeReq.awAddr[N+1:2];                     // Low N bits of the word address
			wrChannel <= writeReq.awAddr[N+1+ChanBits:N+2];        // Channel sits above the index
		end
		if (!dataBusy) begin
			wrValue <= writeReq.wData[M-1:0];  // Upper data bits ignored
		end
	end

	assign writeRsp = '{
		awReady: !addrBusy,
		wReady: !dataBusy,
		bValid: addrBusy && dataBusy,
		bResp: thrBusPkg::respOkay
	};

	// Table write fires with the response handshake
	assign thrWrite = '{
		en: respDone,
		channel: 8'(wrChannel),
		index: 8'(wrIndex),
		value: 16'(wrValue)
	};

	// Read responder, no readback of the tables
	always_ff @(posedge clk) begin
		if (rst) begin
			rdBusy <= 1'b0;
		end else if (rdBusy) begin
			rdBusy <= !readReq.rReady;  // Hold until taken
		end else begin
			rdBusy <= readReq.arValid;
		end
	end

	assign readRsp = '{
		arReady: !rdBusy,
		rValid: rdBusy,
		rData: {thrBusPkg::DataBits{1'b1}},  // Every read answers all ones
		rResp: thrBusPkg::respOkay
	};

endmodule

`default_nettype wire

//--- verilog/outputSkidBuffer.sv
// Two-entry output buffer
// Absorbs the result in flight on a stall and derives the pipeline enable
`timescale 1ns/1ps
`default_nettype none

module outputSkidBuffer (
	input logic clk,
	input logic rst,
	input thrStreamPkg::outBeat result,
	input logic outReady,
	output logic en,
	output thrStreamPkg::outBeat outData
);
	thrStreamPkg::outBeat outReg;   // Presented downstream
	thrStreamPkg::outBeat holdReg;  // Parking slot
	logic outFree;                  // Output register may load

	assign outFree = !outReg.valid || outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outReg.valid <= 1'b0;
			holdReg.valid <= 1'b0;
		end else begin
			if (outFree) begin
				// Parked beat goes first to keep order
				outReg <= holdReg.valid ? holdReg : result;
			end
			// Park when a beat arrives against a stalled output
			holdReg.valid <= outReg.valid && !outReady && (holdReg.valid || result.valid);
			if (!holdReg.valid) begin
				holdReg.data <= result.data;
			end
		end
	end

	// Core freezes while a beat is parked
	assign en = !holdReg.valid;
	assign outData = outReg;

endmodule

`default_nettype wire

//--- verilog/thrBusPkg.sv
// Configuration bus definitions for the thresholding unit
// AXI-Lite-style request and response structs plus the core table write command
`default_nettype none

package thrBusPkg;

	localparam int unsigned AddrBits = 16;  // Byte address
	localparam int unsigned DataBits = 32;
	localparam int unsigned ChanFieldBits = 8;
	localparam int unsigned IndexFieldBits = 8;
	localparam int unsigned ValueFieldBits = 16;

	localparam logic [1:0] respOkay = 2'b00;

	// Write path, driven by the bus master
	typedef struct packed {
		logic awValid;
		logic [AddrBits-1:0] awAddr;
		logic wValid;
		logic [DataBits-1:0] wData;
		logic bReady;
	} axiWriteReq;

	typedef struct packed {
		logic awReady;
		logic wReady;
		logic bValid;
		logic [1:0] bResp;
	} axiWriteRsp;

	// Read path
	typedef struct packed {
		logic arValid;
		logic [AddrBits-1:0] arAddr;  // Not decoded
		logic rReady;
	} axiReadReq;

	typedef struct packed {
		logic arReady;
		logic rValid;
		logic [DataBits-1:0] rData;
		logic [1:0] rResp;
	} axiReadRsp;

	// One threshold table write, valid for a single cycle
	typedef struct packed {
		logic en;
		logic [ChanFieldBits-1:0] channel;
		logic [IndexFieldBits-1:0] index;  // Flat index 0 .. 2^N-2
		logic [ValueFieldBits-1:0] value;
	} thresholdWrite;

endpackage

`default_nettype wire

//--- verilog/thrStreamPkg.sv
// Stream definitions for the thresholding unit
// Input and output beats and the token passed along the search chain
`default_nettype none

package thrStreamPkg;

	localparam int unsigned InLaneBits = 16;
	localparam int unsigned OutLaneBits = 8;
	localparam int unsigned TagBits = 8;  // Channel and prefix fields

	typedef struct packed {
		logic valid;
		logic [InLaneBits-1:0] data;
	} inBeat;

	typedef struct packed {
		logic valid;
		logic [OutLaneBits-1:0] data;
	} outBeat;

	// Search item, prefix grows by one bit per stage
	typedef struct packed {
		logic valid;
		logic [TagBits-1:0] channel;
		logic [InLaneBits-1:0] value;
		logic [TagBits-1:0] prefix;  // Result bits decided so far, LSB newest
	} stageToken;

endpackage

`default_nettype wire

//--- verilog/thresholdCore.sv
// Multi-threshold core
// Tags beats with a rotating channel and runs them through N binary search stages
`timescale 1ns/1ps
`default_nettype none

module thresholdCore #(
	parameter int unsigned N = 4,
	parameter int unsigned M = 8,
	parameter int unsigned C = 3,
	parameter int BIAS = 0  // Added to the threshold count
) (
	input logic clk,
	input logic rst,
	input logic en,  // Global pipeline enable
	input thrBusPkg::thresholdWrite thrWrite,
	input thrStreamPkg::inBeat inData,
	output thrStreamPkg::outBeat result
);
	localparam int unsigned ChanBits = (C < 2) ? 1 : $clog2(C);

	logic [ChanBits-1:0] chan;  // Channel of the beat now at the input
	thrStreamPkg::stageToken tokens [N+1];

	// Round-robin channel, implied by beat order
	if (C == 1) begin : gSingleChan
		assign chan = '0;
	end else begin : gRotateChan
		logic [ChanBits-1:0] chanCnt;
		logic last;    // Counter sits on C-1
		logic accept;

		assign accept = inData.valid && en;

		always_ff @(posedge clk) begin
			if (rst || (last && accept)) begin
				chanCnt <= '0;  // Wrap
				last <= 1'b0;
			end else if (accept) begin
				chanCnt <= chanCnt + 1'b1;
				last <= chanCnt == ChanBits'(C - 2);  // Next one is the final channel
			end
		end

		assign chan = chanCnt;
	end

	// First token, nothing decided yet
	assign tokens[0] = '{
		valid: inData.valid,
		channel: 8'(chan),
		value: inData.data,
		prefix: '0
	};

	for (genvar s = 0; s < N; s++) begin : gStage
		thresholdStage #(
			.STAGE(s),
			.N(N),
			.M(M),
			.C(C)
		) stage (
			.clk(clk),
			.rst(rst),
			.en(en),
			.thrWrite(thrWrite),
			.tokenIn(tokens[s]),
			.tokenOut(tokens[s+1])
		);
	end

	// Count of reached thresholds, offset into the signed output range
	assign result = '{
		valid: tokens[N].valid,
		data: 8'(tokens[N].prefix[N-1:0]) + 8'(BIAS)  // Two's complement wrap in lane
	};

endmodule

`default_nettype wire

//--- verilog/thresholdStage.sv
// One binary search stage of the threshold pipeline
// Holds the C x 2^STAGE thresholds this stage can consult and decides one result bit
`timescale 1ns/1ps
`default_nettype none

module thresholdStage #(
	parameter int unsigned STAGE = 0,  // 0 decides the MSB
	parameter int unsigned N = 4,
	parameter int unsigned M = 8,
	parameter int unsigned C = 3
) (
	input logic clk,
	input logic rst,
	input logic en,
	input thrBusPkg::thresholdWrite thrWrite,
	input thrStreamPkg::stageToken tokenIn,
	output thrStreamPkg::stageToken tokenOut
);
	localparam int unsigned Depth = 2 ** STAGE;  // Reachable prefixes
	localparam int unsigned PosBits = (STAGE < 1) ? 1 : STAGE;
	localparam int unsigned ChanBits = (C < 2) ? 1 : $clog2(C);
	localparam int unsigned TrailZeros = N - 1 - STAGE;
	localparam logic [8:0] TzMask = 9'((1 << (TrailZeros + 1)) - 1);
	localparam logic [8:0] TzBit = 9'(1 << TrailZeros);

	logic [M-1:0] thrMem [C][Depth];
	logic [8:0] idxInc;  // Flat index plus one
	logic wrHit;
	logic [PosBits-1:0] wrPos;
	logic [M-1:0] rdThr;
	logic geBit;
	thrStreamPkg::stageToken nextToken;

	// Only indices whose successor has exactly TrailZeros trailing zeros live here
	assign idxInc = {1'b0, thrWrite.index} + 9'd1;
	assign wrHit = thrWrite.en && (thrWrite.channel < 8'(C)) && ((idxInc & TzMask) == TzBit);
	assign wrPos = PosBits'(idxInc >> (N - STAGE));  // Prefix that selects this threshold

	always_ff @(posedge clk) begin
		if (wrHit) begin
			thrMem[thrWrite.channel[ChanBits-1:0]][wrPos] <= thrWrite.value[M-1:0];
		end
	end

	// Threshold at the middle of the interval left by the prefix
	assign rdThr = thrMem[tokenIn.channel[ChanBits-1:0]][tokenIn.prefix[PosBits-1:0]];
	assign geBit = tokenIn.value[M-1:0] >= rdThr;

	always_comb begin
		nextToken = tokenIn;
		nextToken.prefix = {tokenIn.prefix[6:0], geBit};  // Append decided bit
	end

	// Advances only with the pipeline enable
	always_ff @(posedge clk) begin
		if (rst) begin
			tokenOut.valid <= 1'b0;
		end else if (en) begin
			tokenOut <= nextToken;
		end
	end

endmodule

`default_nettype wire

//--- verilog/thresholdingTop.sv
// Thresholding unit top level
// Connects the configuration slave, the search core and the output buffer
`timescale 1ns/1ps
`default_nettype none

module thresholdingTop #(
	parameter int unsigned N = 4,  // Output bits
	parameter int unsigned M = 8,  // Input bits
	parameter int unsigned C = 3,  // Channels
	parameter int BIAS = 0
) (
	input logic clk,
	input logic rst,
	input thrBusPkg::axiWriteReq writeReq,
	output thrBusPkg::axiWriteRsp writeRsp,
	input thrBusPkg::axiReadReq readReq,
	output thrBusPkg::axiReadRsp readRsp,
	input thrStreamPkg::inBeat inData,
	output logic inReady,
	output thrStreamPkg::outBeat outData,
	input logic outReady
);
	thrBusPkg::thresholdWrite thrWrite;
	thrStreamPkg::outBeat result;  // Core output, before buffering
	logic en;

	configPort #(
		.N(N),
		.M(M),
		.C(C)
	) cfg (
		.clk(clk),
		.rst(rst),
		.writeReq(writeReq),
		.writeRsp(writeRsp),
		.readReq(readReq),
		.readRsp(readRsp),
		.thrWrite(thrWrite)
	);

	thresholdCore #(
		.N(N),
		.M(M),
		.C(C),
		.BIAS(BIAS)
	) core (
		.clk(clk),
		.rst(rst),
		.en(en),
		.thrWrite(thrWrite),
		.inData(inData),
		.result(result)
	);

	outputSkidBuffer skid (
		.clk(clk),
		.rst(rst),
		.result(result),
		.outReady(outReady),
		.en(en),
		.outData(outData)
	);

	assign inReady = en;  // Input accepted whenever the pipeline moves

endmodule

`default_nettype wire
